// ==== iigs_mem_top.f ====
logic/iigs_mem_pkg.sv
logic/mem_bus_if.sv
logic/phase_timer.sv
logic/apb_access_fsm.sv
logic/bank_decoder.sv
logic/mem_arrays.sv
logic/hdd_regs.sv
logic/iigs_mem_top.sv
verif/iigs_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := iigs_mem_tb
RTL_TOP   := iigs_mem_top
FILELIST  := iigs_mem_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := tests failed

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter logic/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/iigs_mem_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module iigs_mem_tb;

  localparam int RAM_BANKS   = 2;
  localparam int PHASE_DIV   = 4;
  localparam int SLOW_RATIO  = 4;
  localparam int MAX_WAITS   = PHASE_DIV * SLOW_RATIO * 2;
  // upper bound on the APB transfers of all tests together
  localparam int MAX_XFERS   = 400;
  // host port fills and idle gaps
  localparam int MARGIN_CLKS = 4000;
  localparam int WATCHDOG_NS = (MAX_XFERS * SLOW_RATIO * PHASE_DIV * 2 + MARGIN_CLKS) * 100;

  localparam logic [7:0]  OPEN_BUS_VAL = 8'h80;
  localparam logic [23:0] SLTROMSEL    = 24'h00C02D;
  localparam logic [23:0] HDD_STATUS   = 24'h00C0F0;
  localparam logic [23:0] HDD_CMD      = 24'h00C0F1;
  localparam logic [23:0] HDD_SEC_LO   = 24'h00C0F2;
  localparam logic [23:0] HDD_SEC_HI   = 24'h00C0F3;
  localparam logic [23:0] HDD_DATA     = 24'h00C0F4;

  logic        clk_sys;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [23:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic [15:0] hdd_sector;
  logic        hdd_read;
  logic        hdd_write;
  logic        hdd_done;
  logic        hdd_mounted;
  logic        hdd_protect;
  logic [8:0]  ram_addr;
  logic [7:0]  ram_di;
  logic [7:0]  ram_do;
  logic        ram_we;

  // reference model keyed by the full 24-bit address
  logic [7:0]  fast_ref [int];
  logic [7:0]  slow_ref [int];
  logic [7:0]  buf_ref [512];

  int          err_count;
  int          tests_run;
  int          tests_failed;
  int          last_waits;

  iigs_mem_top #(
    .RAM_BANKS  (RAM_BANKS),
    .PHASE_DIV  (PHASE_DIV),
    .SLOW_RATIO (SLOW_RATIO)
  ) iigs_mem_top_inst (
    .clk_sys     (clk_sys),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .hdd_sector  (hdd_sector),
    .hdd_read    (hdd_read),
    .hdd_write   (hdd_write),
    .hdd_done    (hdd_done),
    .hdd_mounted (hdd_mounted),
    .hdd_protect (hdd_protect),
    .ram_addr    (ram_addr),
    .ram_di      (ram_di),
    .ram_do      (ram_do),
    .ram_we      (ram_we)
  );

  initial
  begin
    clk_sys = 1'b0;
    forever #50 clk_sys = ~clk_sys;
  end

  // expected status register byte
  function automatic logic [7:0] status_byte(input logic busy, input logic protect,
                                             input logic mounted);
    return {busy, 5'b00000, protect, mounted};
  endfunction

  task automatic report_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
    $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
    err_count++;
  endtask

  task automatic end_test(input string name, input int start_errs);
    tests_run++;
    if (err_count != start_errs)
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - start_errs);
    end
    else
      $display("test %s: ok", name);
  endtask

  // one APB transfer
  // last_waits counts access cycles with pready low
  task automatic apb_xfer(input logic wr, input logic [23:0] addr, input logic [7:0] wdata,
                          output logic [7:0] rdata);
    int waits;
    waits = 0;
    @(posedge clk_sys);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk_sys);
    penable <= 1'b1;
    @(posedge clk_sys);
    while (!pready && waits < MAX_WAITS)
    begin
      waits++;
      @(posedge clk_sys);
    end
    rdata      = prdata;
    last_waits = waits;
    if (!pready)
    begin
      $display("no pready from the DUT within %0d cycles for address %h at %0t ns",
               MAX_WAITS, addr, $time);
      err_count++;
    end
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [23:0] addr, input logic [7:0] data);
    logic [7:0] unused_rd;
    apb_xfer(1'b1, addr, data, unused_rd);
  endtask

  task automatic apb_read(input logic [23:0] addr, output logic [7:0] data);
    apb_xfer(1'b0, addr, 8'h00, data);
  endtask

  // host side fills the whole sector buffer with random bytes
  task automatic host_fill();
    for (int i = 0; i < 512; i++)
    begin
      buf_ref[i] = 8'($urandom);
      @(posedge clk_sys);
      ram_addr <= 9'(i);
      ram_di   <= buf_ref[i];
      ram_we   <= 1'b1;
    end
    @(posedge clk_sys);
    ram_we <= 1'b0;
  endtask

  task automatic done_pulse();
    @(posedge clk_sys);
    hdd_done <= 1'b1;
    @(posedge clk_sys);
    hdd_done <= 1'b0;
  endtask

  task automatic ram_readback();
    int          start_errs;
    logic [23:0] addr;
    logic [7:0]  data;
    logic [7:0]  rd;
    logic [7:0]  banks [4];
    start_errs = err_count;
    banks[0] = 8'h00;
    banks[1] = 8'h01;
    banks[2] = 8'hE0;
    banks[3] = 8'hE1;
    for (int i = 0; i < 24; i++)
    begin
      addr = {banks[i % 4], 16'($urandom % 32'hC000)};
      data = 8'($urandom);
      apb_write(addr, data);
      if (addr[23:16] >= 8'hE0)
        slow_ref[int'(addr)] = data;
      else
        fast_ref[int'(addr)] = data;
    end
    // same offset in 01 and E1 must hold different bytes
    apb_write(24'h011234, 8'hA5);
    fast_ref[int'(24'h011234)] = 8'hA5;
    apb_write(24'hE11234, 8'h5A);
    slow_ref[int'(24'hE11234)] = 8'h5A;
    foreach (fast_ref[key])
    begin
      apb_read(24'(key), rd);
      if (rd !== fast_ref[key])
        report_value($sformatf("fast RAM read %h", 24'(key)), 16'(rd), 16'(fast_ref[key]));
    end
    foreach (slow_ref[key])
    begin
      apb_read(24'(key), rd);
      if (rd !== slow_ref[key])
        report_value($sformatf("slow RAM read %h", 24'(key)), 16'(rd), 16'(slow_ref[key]));
    end
    end_test("ram_readback", start_errs);
  endtask

  task automatic wait_state_bounds();
    int         start_errs;
    int         max_fast;
    int         max_slow;
    int         min_waits;
    logic [7:0] rd;
    start_errs = err_count;
    max_fast   = 0;
    max_slow   = 0;
    min_waits  = MAX_WAITS;
    for (int i = 0; i < 8; i++)
    begin
      // random gaps shift the access against the phase timer
      repeat ($urandom % 5) @(posedge clk_sys);
      apb_read({8'h00, 16'(16'h0100 + i)}, rd);
      if (last_waits > max_fast)
        max_fast = last_waits;
      if (last_waits < min_waits)
        min_waits = last_waits;
      repeat ($urandom % 7) @(posedge clk_sys);
      apb_read({8'hE0, 16'(16'h0200 + i)}, rd);
      if (last_waits > max_slow)
        max_slow = last_waits;
      if (last_waits < min_waits)
        min_waits = last_waits;
    end
    if (max_fast > PHASE_DIV)
      report_value("fast RAM wait cycles above bound", 16'(max_fast), 16'(PHASE_DIV));
    if (max_slow > PHASE_DIV * SLOW_RATIO)
      report_value("slow RAM wait cycles above bound", 16'(max_slow),
                   16'(PHASE_DIV * SLOW_RATIO));
    if (min_waits < 1)
      report_value("access shorter than one wait cycle", 16'(min_waits), 16'd1);
    end_test("wait_state_bounds", start_errs);
  endtask

  task automatic open_bus_reads();
    int          start_errs;
    logic [7:0]  rd;
    logic [23:0] addrs [3];
    start_errs = err_count;
    addrs[0] = 24'hFE1234;
    addrs[1] = {8'(RAM_BANKS), 16'h2000};
    addrs[2] = 24'h00C456;
    for (int i = 0; i < 3; i++)
    begin
      apb_read(addrs[i], rd);
      if (rd !== OPEN_BUS_VAL)
        report_value($sformatf("open bus read %h", addrs[i]), 16'(rd), 16'(OPEN_BUS_VAL));
      apb_write(addrs[i], 8'h3C);
      apb_read(addrs[i], rd);
      if (rd !== OPEN_BUS_VAL)
        report_value($sformatf("read after write %h", addrs[i]), 16'(rd), 16'(OPEN_BUS_VAL));
    end
    end_test("open_bus_reads", start_errs);
  endtask

  task automatic slot_select();
    int         start_errs;
    logic [7:0] rd;
    start_errs = err_count;
    apb_write(SLTROMSEL, 8'h5A);
    apb_read(SLTROMSEL, rd);
    if (rd !== 8'h5A)
      report_value("SLTROMSEL readback", 16'(rd), 16'h005A);
    // slot 7 still internal
    apb_read(HDD_STATUS, rd);
    if (rd !== OPEN_BUS_VAL)
      report_value("C0F0 with slot 7 internal", 16'(rd), 16'(OPEN_BUS_VAL));
    @(posedge clk_sys);
    hdd_mounted <= 1'b1;
    hdd_protect <= 1'b1;
    apb_write(SLTROMSEL, 8'h82);
    apb_read(SLTROMSEL, rd);
    if (rd !== 8'h82)
      report_value("SLTROMSEL readback", 16'(rd), 16'h0082);
    apb_read(HDD_STATUS, rd);
    if (rd !== status_byte(1'b0, 1'b1, 1'b1))
      report_value("disk status", 16'(rd), 16'(status_byte(1'b0, 1'b1, 1'b1)));
    host_fill();
    for (int i = 0; i < 256; i++)
    begin
      apb_read({16'h00C7, 8'(i)}, rd);
      if (rd !== buf_ref[i])
        report_value($sformatf("boot block byte %0d", i), 16'(rd), 16'(buf_ref[i]));
    end
    end_test("slot_select", start_errs);
  endtask

  task automatic disk_read_cmd();
    int          start_errs;
    logic [15:0] sector;
    logic [7:0]  rd;
    start_errs = err_count;
    sector     = 16'($urandom);
    apb_write(HDD_SEC_LO, sector[7:0]);
    apb_write(HDD_SEC_HI, sector[15:8]);
    apb_write(HDD_CMD, 8'h01);
    apb_read(HDD_STATUS, rd);
    if (rd !== status_byte(1'b1, 1'b1, 1'b1))
      report_value("status while busy", 16'(rd), 16'(status_byte(1'b1, 1'b1, 1'b1)));
    if (hdd_read !== 1'b1)
      report_value("hdd_read after read command", 16'(hdd_read), 16'd1);
    if (hdd_write !== 1'b0)
      report_value("hdd_write after read command", 16'(hdd_write), 16'd0);
    if (hdd_sector !== sector)
      report_value("hdd_sector", hdd_sector, sector);
    done_pulse();
    apb_read(HDD_STATUS, rd);
    if (rd !== status_byte(1'b0, 1'b1, 1'b1))
      report_value("status after done", 16'(rd), 16'(status_byte(1'b0, 1'b1, 1'b1)));
    if (hdd_read !== 1'b0)
      report_value("hdd_read after done", 16'(hdd_read), 16'd0);
    apb_read(HDD_SEC_LO, rd);
    if (rd !== sector[7:0])
      report_value("sector low readback", 16'(rd), 16'(sector[7:0]));
    // command write reset the pointer to byte 0
    for (int i = 0; i < 16; i++)
    begin
      apb_read(HDD_DATA, rd);
      if (rd !== buf_ref[i])
        report_value($sformatf("data port byte %0d", i), 16'(rd), 16'(buf_ref[i]));
    end
    end_test("disk_read_cmd", start_errs);
  endtask

  task automatic disk_write_cmd();
    int         start_errs;
    logic [7:0] data;
    logic [7:0] rd;
    start_errs = err_count;
    @(posedge clk_sys);
    hdd_protect <= 1'b0;
    apb_write(HDD_CMD, 8'h00);
    for (int i = 0; i < 16; i++)
    begin
      data       = 8'($urandom);
      buf_ref[i] = data;
      apb_write(HDD_DATA, data);
    end
    // one address per cycle and each byte shows up a cycle later
    for (int i = 0; i < 18; i++)
    begin
      @(posedge clk_sys);
      if (i >= 2 && ram_do !== buf_ref[i - 2])
        report_value($sformatf("ram_do byte %0d", i - 2), 16'(ram_do), 16'(buf_ref[i - 2]));
      if (i < 16)
        ram_addr <= 9'(i);
    end
    apb_write(HDD_CMD, 8'h02);
    @(posedge clk_sys);
    if (hdd_write !== 1'b1)
      report_value("hdd_write after write command", 16'(hdd_write), 16'd1);
    if (hdd_read !== 1'b0)
      report_value("hdd_read after write command", 16'(hdd_read), 16'd0);
    apb_read(HDD_STATUS, rd);
    if (rd !== status_byte(1'b1, 1'b0, 1'b1))
      report_value("status while writing", 16'(rd), 16'(status_byte(1'b1, 1'b0, 1'b1)));
    done_pulse();
    @(posedge clk_sys);
    hdd_protect <= 1'b1;
    apb_write(HDD_CMD, 8'h02);
    repeat (2) @(posedge clk_sys);
    if (hdd_write !== 1'b0)
      report_value("hdd_write on protected media", 16'(hdd_write), 16'd0);
    end_test("disk_write_cmd", start_errs);
  endtask

  initial
  begin
    void'($urandom(32'h36b58195));
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    last_waits   = 0;
    arst_n       = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = 24'h000000;
    pwdata       = 8'h00;
    hdd_done     = 1'b0;
    hdd_mounted  = 1'b0;
    hdd_protect  = 1'b0;
    ram_addr     = 9'd0;
    ram_di       = 8'h00;
    ram_we       = 1'b0;
    repeat (4) @(posedge clk_sys);
    arst_n <= 1'b1;
    @(posedge clk_sys);
    ram_readback();
    wait_state_bounds();
    open_bus_reads();
    slot_select();
    disk_read_cmd();
    disk_write_cmd();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // ends a hung run
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the DUT or a test is stuck", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/iigs_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module iigs_mem_top #(
  parameter int RAM_BANKS  = 2,
  parameter int PHASE_DIV  = 4,
  parameter int SLOW_RATIO = 4
) (
  input  logic        clk_sys,
  input  logic        arst_n,
  // APB slave
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [23:0] paddr,
  input  logic [7:0]  pwdata,
  output logic [7:0]  prdata,
  output logic        pready,
  // disk host
  output logic [15:0] hdd_sector,
  output logic        hdd_read,
  output logic        hdd_write,
  input  logic        hdd_done,
  input  logic        hdd_mounted,
  input  logic        hdd_protect,
  // sector buffer host port
  input  logic [8:0]  ram_addr,
  input  logic [7:0]  ram_di,
  output logic [7:0]  ram_do,
  input  logic        ram_we
);

  logic       fast_phase;
  logic       slow_phase;
  logic       fast_sel;
  logic       slow_sel;
  logic       hdd_io_sel;
  logic       card_rom_sel;
  logic [7:0] fast_rdata;
  logic [7:0] slow_rdata;
  logic [7:0] hdd_rdata;

  mem_bus_if mem_bus ();

  phase_timer #(
    .PHASE_DIV  (PHASE_DIV),
    .SLOW_RATIO (SLOW_RATIO)
  ) phase_timer_inst (
    .clk_sys    (clk_sys),
    .arst_n     (arst_n),
    .fast_phase (fast_phase),
    .slow_phase (slow_phase)
  );

  apb_access_fsm apb_access_fsm_inst (
    .clk_sys    (clk_sys),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .pready     (pready),
    .fast_phase (fast_phase),
    .slow_phase (slow_phase),
    .bus        (mem_bus.seq)
  );

  bank_decoder #(
    .RAM_BANKS (RAM_BANKS)
  ) bank_decoder_inst (
    .clk_sys      (clk_sys),
    .arst_n       (arst_n),
    .bus          (mem_bus.dec),
    .fast_rdata   (fast_rdata),
    .slow_rdata   (slow_rdata),
    .hdd_rdata    (hdd_rdata),
    .fast_sel     (fast_sel),
    .slow_sel     (slow_sel),
    .hdd_io_sel   (hdd_io_sel),
    .card_rom_sel (card_rom_sel)
  );

  mem_arrays #(
    .RAM_BANKS (RAM_BANKS)
  ) mem_arrays_inst (
    .clk_sys    (clk_sys),
    .bus        (mem_bus.target),
    .fast_sel   (fast_sel),
    .slow_sel   (slow_sel),
    .fast_rdata (fast_rdata),
    .slow_rdata (slow_rdata)
  );

  hdd_regs hdd_regs_inst (
    .clk_sys      (clk_sys),
    .arst_n       (arst_n),
    .bus          (mem_bus.target),
    .hdd_io_sel   (hdd_io_sel),
    .card_rom_sel (card_rom_sel),
    .hdd_rdata    (hdd_rdata),
    .hdd_sector   (hdd_sector),
    .hdd_read     (hdd_read),
    .hdd_write    (hdd_write),
    .hdd_done     (hdd_done),
    .hdd_mounted  (hdd_mounted),
    .hdd_protect  (hdd_protect),
    .ram_addr     (ram_addr),
    .ram_di       (ram_di),
    .ram_we       (ram_we),
    .ram_do       (ram_do)
  );

  // read data is valid while pready is high
  assign prdata = mem_bus.rdata;

endmodule

`default_nettype wire

// ==== logic/hdd_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdd_regs (
  input  logic        clk_sys,
  input  logic        arst_n,
  mem_bus_if.target   bus,
  input  logic        hdd_io_sel,
  input  logic        card_rom_sel,
  output logic [7:0]  hdd_rdata,
  output logic [15:0] hdd_sector,
  output logic        hdd_read,
  output logic        hdd_write,
  input  logic        hdd_done,
  input  logic        hdd_mounted,
  input  logic        hdd_protect,
  input  logic [8:0]  ram_addr,
  input  logic [7:0]  ram_di,
  input  logic        ram_we,
  output logic [7:0]  ram_do
);

  logic [7:0]  sector_buf [512];
  logic [7:0]  cmd_q;
  logic [15:0] sector_q;
  logic [8:0]  ptr;
  logic        busy;
  logic        reg_wr;
  logic        cmd_wr;
  logic        data_acc;
  logic [7:0]  io_rdata;

  assign reg_wr   = bus.commit && bus.write && hdd_io_sel;
  assign cmd_wr   = reg_wr && (bus.addr.io.reg_sel == 4'd1);
  // reads and writes of the data port both advance the pointer
  assign data_acc = bus.commit && hdd_io_sel && (bus.addr.io.reg_sel == 4'd4);
  assign busy     = hdd_read || hdd_write;

  always_ff @(posedge clk_sys or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cmd_q     <= 8'h00;
      sector_q  <= 16'h0000;
      ptr       <= 9'd0;
      hdd_read  <= 1'b0;
      hdd_write <= 1'b0;
    end
    else
    begin
      if (reg_wr && bus.addr.io.reg_sel == 4'd2)
        sector_q[7:0] <= bus.wdata;
      if (reg_wr && bus.addr.io.reg_sel == 4'd3)
        sector_q[15:8] <= bus.wdata;

      if (cmd_wr)
        ptr <= 9'd0;
      else if (data_acc)
        ptr <= ptr + 1'b1;

      // request held until the host acknowledges
      if (hdd_done)
      begin
        hdd_read  <= 1'b0;
        hdd_write <= 1'b0;
      end
      else if (cmd_wr)
      begin
        cmd_q <= bus.wdata;
        if (bus.wdata == iigs_mem_pkg::CMD_READ)
          hdd_read <= 1'b1;
        // write protected media ignores the write command
        if (bus.wdata == iigs_mem_pkg::CMD_WRITE && !hdd_protect)
          hdd_write <= 1'b1;
      end
    end
  end

  // sector buffer, bus side through the data port and host side on ram_*
  always_ff @(posedge clk_sys)
  begin
    if (ram_we)
      sector_buf[ram_addr] <= ram_di;
    if (data_acc && bus.write)
      sector_buf[ptr] <= bus.wdata;
    ram_do <= sector_buf[ram_addr];
  end

  always_comb
  begin
    case (bus.addr.io.reg_sel)
      4'd0:    io_rdata = {busy, 5'b00000, hdd_protect, hdd_mounted};
      4'd1:    io_rdata = cmd_q;
      4'd2:    io_rdata = sector_q[7:0];
      4'd3:    io_rdata = sector_q[15:8];
      4'd4:    io_rdata = sector_buf[ptr];
      default: io_rdata = iigs_mem_pkg::OPEN_BUS;
    endcase
  end

  // card ROM page shows the boot block, first half of the buffer
  assign hdd_rdata = card_rom_sel ? sector_buf[{1'b0, bus.addr.flat.offset[7:0]}] :
                     hdd_io_sel   ? io_rdata : iigs_mem_pkg::OPEN_BUS;

  assign hdd_sector = sector_q;

endmodule

`default_nettype wire

// ==== logic/mem_arrays.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arrays #(
  parameter int RAM_BANKS = 2
) (
  input  logic       clk_sys,
  mem_bus_if.target  bus,
  input  logic       fast_sel,
  input  logic       slow_sel,
  output logic [7:0] fast_rdata,
  output logic [7:0] slow_rdata
);

  localparam int BW = (RAM_BANKS > 1) ? $clog2(RAM_BANKS) : 1;

  logic [7:0]     fast_mem [RAM_BANKS * 65536];
  // banks E0 and E1
  logic [7:0]     slow_mem [131072];
  logic [BW+15:0] fast_idx;
  logic [16:0]    slow_idx;

  assign fast_idx = {bus.addr.flat.bank[BW-1:0], bus.addr.flat.offset};
  assign slow_idx = {bus.addr.flat.bank[0], bus.addr.flat.offset};

  always_ff @(posedge clk_sys)
  begin
    if (bus.commit && bus.write && fast_sel)
      fast_mem[fast_idx] <= bus.wdata;
  end

  always_ff @(posedge clk_sys)
  begin
    if (bus.commit && bus.write && slow_sel)
      slow_mem[slow_idx] <= bus.wdata;
  end

  // address is held through the whole access
  assign fast_rdata = fast_mem[fast_idx];
  assign slow_rdata = slow_mem[slow_idx];

endmodule

`default_nettype wire

// ==== logic/bank_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_decoder #(
  parameter int RAM_BANKS = 2
) (
  input  logic       clk_sys,
  input  logic       arst_n,
  mem_bus_if.dec     bus,
  input  logic [7:0] fast_rdata,
  input  logic [7:0] slow_rdata,
  input  logic [7:0] hdd_rdata,
  output logic       fast_sel,
  output logic       slow_sel,
  output logic       hdd_io_sel,
  output logic       card_rom_sel
);

  // C000-C7FF as seen by offset bits 15..11
  localparam logic [4:0] IO_PAGE = 5'b11000;
  localparam logic [7:0] BANK_LIMIT = 8'(RAM_BANKS);

  logic [7:0] sltromsel;
  logic [7:0] bank;
  logic       io_bank;
  logic       dev_win;
  logic       rom_win;
  logic       rom_space;

  assign bank    = bus.addr.flat.bank;
  assign io_bank = (bank == 8'h00) || (bank == 8'h01) || (bank == 8'hE0) || (bank == 8'hE1);

  // C090-C0FF device select, slots 1..7
  assign dev_win = io_bank && (bus.addr.io.region == IO_PAGE) && (bus.addr.io.rom_slot == 3'd0)
                   && bus.addr.io.dev_hi && (bus.addr.io.dev_slot != 3'd0);
  // C400-C7FF slot ROM
  assign rom_win = io_bank && (bus.addr.io.region == IO_PAGE) && bus.addr.io.rom_slot[2];

  // system ROM banks and the ROM above C100 in bank 00
  assign rom_space = (bank == 8'hFE) || (bank == 8'hFF)
                     || ((bank == 8'h00) && (bus.addr.flat.offset >= 16'hC100));

  always_comb
  begin
    if (bus.addr == iigs_mem_pkg::SLTROMSEL_ADDR)
      bus.region = iigs_mem_pkg::REGION_CTRL;
    else if (dev_win)
    begin
      // internal devices are not modelled, only the disk card answers
      if (sltromsel[bus.addr.io.dev_slot] && bus.addr.io.dev_slot == iigs_mem_pkg::HDD_SLOT)
        bus.region = iigs_mem_pkg::REGION_HDD_IO;
      else
        bus.region = iigs_mem_pkg::REGION_OPEN;
    end
    else if (rom_win)
    begin
      if (sltromsel[bus.addr.io.rom_slot] && bus.addr.io.rom_slot == iigs_mem_pkg::HDD_SLOT)
        bus.region = iigs_mem_pkg::REGION_CARD_ROM;
      else
        bus.region = iigs_mem_pkg::REGION_OPEN;
    end
    else if (rom_space)
      bus.region = iigs_mem_pkg::REGION_OPEN;
    else if (bank < BANK_LIMIT)
      bus.region = iigs_mem_pkg::REGION_FAST;
    else if ((bank == 8'hE0) || (bank == 8'hE1))
      bus.region = iigs_mem_pkg::REGION_SLOW;
    else
      bus.region = iigs_mem_pkg::REGION_OPEN;
  end

  assign fast_sel     = (bus.region == iigs_mem_pkg::REGION_FAST);
  assign slow_sel     = (bus.region == iigs_mem_pkg::REGION_SLOW);
  assign hdd_io_sel   = (bus.region == iigs_mem_pkg::REGION_HDD_IO);
  assign card_rom_sel = (bus.region == iigs_mem_pkg::REGION_CARD_ROM);

  // bit n set puts slot n on the external card
  always_ff @(posedge clk_sys or negedge arst_n)
  begin
    if (!arst_n)
      sltromsel <= 8'h00;
    else if (bus.commit && bus.write && bus.region == iigs_mem_pkg::REGION_CTRL)
      sltromsel <= bus.wdata;
  end

  always_comb
  begin
    case (bus.region)
      iigs_mem_pkg::REGION_FAST:     bus.rdata = fast_rdata;
      iigs_mem_pkg::REGION_SLOW:     bus.rdata = slow_rdata;
      iigs_mem_pkg::REGION_HDD_IO:   bus.rdata = hdd_rdata;
      iigs_mem_pkg::REGION_CARD_ROM: bus.rdata = hdd_rdata;
      iigs_mem_pkg::REGION_CTRL:     bus.rdata = sltromsel;
      default:                       bus.rdata = iigs_mem_pkg::OPEN_BUS;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/apb_access_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_access_fsm (
  input  logic        clk_sys,
  input  logic        arst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [23:0] paddr,
  input  logic [7:0]  pwdata,
  output logic        pready,
  input  logic        fast_phase,
  input  logic        slow_phase,
  mem_bus_if.seq      bus
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_WAIT = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0]              state;
  logic                    setup;
  logic                    phase_hit;
  iigs_mem_pkg::mem_addr_u addr_q;
  logic [7:0]              wdata_q;
  logic                    write_q;

  assign setup = psel && !penable;

  // slow RAM waits for the slow phase, everything else for the fast one
  assign phase_hit = (bus.region == iigs_mem_pkg::REGION_SLOW) ? slow_phase : fast_phase;

  always_ff @(posedge clk_sys or negedge arst_n)
  begin
    if (!arst_n)
      state <= ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE:
          if (setup)
            state <= ST_WAIT;
        ST_WAIT:
          if (penable && phase_hit)
            state <= ST_DONE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // capture the transfer at setup, master keeps it stable anyway
  always_ff @(posedge clk_sys)
  begin
    if (state == ST_IDLE && setup)
    begin
      addr_q  <= paddr;
      wdata_q <= pwdata;
      write_q <= pwrite;
    end
  end

  assign pready     = (state == ST_DONE);
  assign bus.commit = pready;
  assign bus.addr   = addr_q;
  assign bus.wdata  = wdata_q;
  assign bus.write  = write_q;

endmodule

`default_nettype wire

// ==== logic/phase_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module phase_timer #(
  parameter int PHASE_DIV  = 4,
  parameter int SLOW_RATIO = 4
) (
  input  logic clk_sys,
  input  logic arst_n,
  output logic fast_phase,
  output logic slow_phase
);

  localparam int PW = (PHASE_DIV > 1) ? $clog2(PHASE_DIV) : 1;
  localparam int SW = (SLOW_RATIO > 1) ? $clog2(SLOW_RATIO) : 1;

  logic [PW-1:0] phase_cnt;
  logic [SW-1:0] slow_cnt;

  // last system clock of each fast phase
  assign fast_phase = (phase_cnt == PW'(PHASE_DIV - 1));
  // every SLOW_RATIO-th fast phase is also a slow phase
  assign slow_phase = fast_phase && (slow_cnt == SW'(SLOW_RATIO - 1));

  always_ff @(posedge clk_sys or negedge arst_n)
  begin
    if (!arst_n)
    begin
      phase_cnt <= '0;
      slow_cnt  <= '0;
    end
    else if (fast_phase)
    begin
      phase_cnt <= '0;
      if (slow_phase)
        slow_cnt <= '0;
      else
        slow_cnt <= slow_cnt + 1'b1;
    end
    else
    begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;

  // held access from the sequencer
  iigs_mem_pkg::mem_addr_u addr;
  logic [7:0]              wdata;
  logic                    write;
  // one-cycle strobe, same cycle as pready
  logic                    commit;

  // decode result and selected read data
  logic [2:0]              region;
  logic [7:0]              rdata;

  modport seq (
    output addr,
    output wdata,
    output write,
    output commit,
    input  region
  );

  modport dec (
    input  addr,
    input  wdata,
    input  write,
    input  commit,
    output region,
    output rdata
  );

  modport target (
    input addr,
    input wdata,
    input write,
    input commit
  );

endinterface

`default_nettype wire

// ==== logic/iigs_mem_pkg.sv ====
`default_nettype none

package iigs_mem_pkg;

  // one 24-bit bank:offset word, seen as flat memory or as I/O fields
  typedef union packed {
    struct packed {
      logic [7:0]  bank;
      logic [15:0] offset;
    } flat;
    struct packed {
      logic [7:0] bank;
      // offset bits 15..11
      logic [4:0] region;
      // CnXX slot number
      logic [2:0] rom_slot;
      logic       dev_hi;
      // C0nX slot number
      logic [2:0] dev_slot;
      logic [3:0] reg_sel;
    } io;
  } mem_addr_u;

  // region codes from the decoder
  localparam logic [2:0] REGION_FAST     = 3'd0;
  localparam logic [2:0] REGION_SLOW     = 3'd1;
  localparam logic [2:0] REGION_HDD_IO   = 3'd2;
  localparam logic [2:0] REGION_CARD_ROM = 3'd3;
  localparam logic [2:0] REGION_CTRL     = 3'd4;
  localparam logic [2:0] REGION_OPEN     = 3'd5;

  // floating data bus value
  localparam logic [7:0]  OPEN_BUS       = 8'h80;
  localparam logic [23:0] SLTROMSEL_ADDR = 24'h00C02D;
  localparam logic [2:0]  HDD_SLOT       = 3'd7;

  // disk controller commands
  localparam logic [7:0] CMD_READ  = 8'd1;
  localparam logic [7:0] CMD_WRITE = 8'd2;

endpackage

`default_nettype wire
